// ==== logic/uart_pkg.sv ====
package uart_pkg;

    // receiver sequencer, one state per bit centre still to come
    typedef enum logic [3:0] {
        idle  = 4'd0,   // waiting for start, or checking the start centre
        bit_0 = 4'd1,
        bit_1 = 4'd2,
        bit_2 = 4'd3,
        bit_3 = 4'd4,
        bit_4 = 4'd5,
        bit_5 = 4'd6,
        bit_6 = 4'd7,
        bit_7 = 4'd8,
        stop  = 4'd9    // byte reported at stop centre
    } rx_state_t;

    // 16x oversampling of the serial line
    localparam int oversample = 16;

    // data bits per frame, lsb first, no parity
    localparam int data_bits = 8;

endpackage

// ==== logic/stream_pkg.sv ====
package stream_pkg;

    localparam int byte_width   = 8;
    localparam int word_width   = 2 * byte_width;
    localparam int credit_width = 2;   // holds 0..2 credits

    typedef logic [byte_width-1:0]   byte_t;
    typedef logic [word_width-1:0]   word_t;
    typedef logic [credit_width-1:0] credit_t;

endpackage

// ==== logic/baud_tick_gen.sv ====
`timescale 1ns/100ps

module baud_tick_gen #(
    parameter int tick_divisor = 27
) (
    input  logic clock,
    input  logic reset,
    output logic tick
);

    localparam int count_width = (tick_divisor > 1) ? $clog2(tick_divisor) : 1;

    logic [count_width-1:0] count;

    // tick is registered so the strobe is one clean clock wide
    always_ff @(posedge clock) begin
        if (reset) begin
            count <= '0;
            tick  <= 1'b0;
        end else if (count == count_width'(tick_divisor - 1)) begin
            count <= '0;
            tick  <= 1'b1;   // wrap
        end else begin
            count <= count + 1'b1;
            tick  <= 1'b0;
        end
    end

endmodule

// ==== logic/uart_rx.sv ====
`timescale 1ns/100ps

module uart_rx
    import uart_pkg::*;
    import stream_pkg::*;
(
    input  logic  clock,
    input  logic  reset,
    input  logic  tick,
    input  logic  rxd,
    output byte_t rx_byte,
    output logic  byte_valid
);

    localparam int spacing_width = $clog2(oversample);

    logic [1:0]               rxd_sync;
    logic [1:0]               filter_count;
    logic                     rx_bit;
    logic                     rx_bit_prev;
    logic                     start_edge;
    logic                     locked;
    logic [spacing_width-1:0] spacing;
    logic                     next_bit;
    rx_state_t                state;

    always_ff @(posedge clock) begin
        if (reset) begin
            rxd_sync <= 2'b11;   // line idles high
        end else begin
            rxd_sync <= {rxd_sync[0], rxd};
        end
    end

    // saturating vote counter, moves the filtered bit only at the rails
    always_ff @(posedge clock) begin
        if (reset) begin
            filter_count <= 2'd0;
            rx_bit       <= 1'b1;
            rx_bit_prev  <= 1'b1;
        end else if (tick) begin
            if (!rxd_sync[1] && filter_count != 2'd3) begin
                filter_count <= filter_count + 2'd1;
            end else if (rxd_sync[1] && filter_count != 2'd0) begin
                filter_count <= filter_count - 2'd1;
            end
            if (filter_count == 2'd3) begin
                rx_bit <= 1'b0;
            end else if (filter_count == 2'd0) begin
                rx_bit <= 1'b1;
            end
            rx_bit_prev <= rx_bit;
        end
    end

    assign start_edge = rx_bit_prev && !rx_bit;
    assign next_bit   = tick && locked && (spacing == spacing_width'(oversample - 1));

    // spacing counter wraps once per bit, next_bit lands on bit centres
    always_ff @(posedge clock) begin
        if (reset) begin
            locked  <= 1'b0;
            spacing <= '0;
            state   <= idle;
        end else if (tick) begin
            spacing <= spacing + 1'b1;
            if (!locked) begin
                if (start_edge) begin
                    locked  <= 1'b1;
                    spacing <= spacing_width'(oversample / 2 - 1);   // half a bit to start centre
                end
            end else if (next_bit) begin
                case (state)
                    idle: begin
                        if (rx_bit) begin
                            locked <= 1'b0;   // false start
                        end else begin
                            state <= bit_0;
                        end
                    end
                    bit_7: state <= stop;
                    stop: begin
                        state  <= idle;
                        locked <= 1'b0;   // stop bit not checked
                    end
                    default: state <= rx_state_t'(state + 4'd1);
                endcase
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            rx_byte <= '0;
        end else if (next_bit && (state inside {[bit_0:bit_7]})) begin
            rx_byte <= {rx_bit, rx_byte[data_bits-1:1]};   // lsb first
        end
    end

    assign byte_valid = next_bit && (state == stop);

endmodule

// ==== logic/rx_fifo.sv ====
`timescale 1ns/100ps

module rx_fifo
    import stream_pkg::*;
#(
    parameter int fifo_depth = 8,
    parameter int credits    = 2
) (
    input  logic    clock,
    input  logic    reset,
    input  byte_t   rx_byte,
    input  logic    byte_valid,
    output byte_t   fifo_byte,
    output logic    fifo_valid,
    input  credit_t credit_return,
    output logic    overrun
);

    localparam int ptr_width   = $clog2(fifo_depth);
    localparam int count_width = $clog2(fifo_depth + 1);

    byte_t                  mem [fifo_depth];
    logic [ptr_width-1:0]   wr_ptr;
    logic [ptr_width-1:0]   rd_ptr;
    logic [count_width-1:0] count;
    credit_t                credit_count;
    logic                   full;
    logic                   empty;
    logic                   push;
    logic                   pop;

    assign full  = (count == count_width'(fifo_depth));
    assign empty = (count == '0);
    assign push  = byte_valid && !full;   // line cannot wait, excess is dropped
    assign pop   = !empty && (credit_count != '0);

    assign fifo_valid = pop;   // assembler always takes it
    assign fifo_byte  = mem[rd_ptr];

    always_ff @(posedge clock) begin
        if (push) begin
            mem[wr_ptr] <= rx_byte;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;   // depth is a power of two
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + count_width'(push) - count_width'(pop);
        end
    end

    // one credit per byte handed out, returned in pairs by the assembler
    always_ff @(posedge clock) begin
        if (reset) begin
            credit_count <= credit_t'(credits);
        end else begin
            credit_count <= credit_count - credit_t'(pop) + credit_return;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            overrun <= 1'b0;
        end else if (byte_valid && full) begin
            overrun <= 1'b1;   // sticky
        end
    end

endmodule

// ==== logic/word_assembler.sv ====
`timescale 1ns/100ps

module word_assembler
    import stream_pkg::*;
(
    input  logic    clock,
    input  logic    reset,
    input  byte_t   fifo_byte,
    input  logic    fifo_valid,
    output credit_t credit_return,
    output word_t   word,
    output logic    word_valid,
    input  logic    word_ready
);

    localparam int slots = 2;

    byte_t low_byte;
    byte_t high_byte;
    logic  have_low;
    logic  handoff;

    assign handoff = word_valid && word_ready;

    // no byte arrives while the word is held, the credits are all out
    always_ff @(posedge clock) begin
        if (reset) begin
            have_low   <= 1'b0;
            word_valid <= 1'b0;
        end else if (handoff) begin
            word_valid <= 1'b0;
        end else if (fifo_valid) begin
            if (have_low) begin
                have_low   <= 1'b0;
                word_valid <= 1'b1;   // second byte completes the word
            end else begin
                have_low <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (fifo_valid && !have_low) begin
            low_byte <= fifo_byte;
        end
        if (fifo_valid && have_low) begin
            high_byte <= fifo_byte;
        end
    end

    assign word          = {high_byte, low_byte};   // first byte in the low half
    assign credit_return = handoff ? credit_t'(slots) : '0;

endmodule

// ==== logic/serial_rx_top.sv ====
`timescale 1ns/100ps

module serial_rx_top
    import stream_pkg::*;
#(
    parameter int tick_divisor = 27,   // 50 MHz clock, 115200 baud
    parameter int fifo_depth   = 8,
    parameter int credits      = 2
) (
    input  logic  clock,
    input  logic  reset,
    input  logic  rxd,
    output word_t word,
    output logic  word_valid,
    input  logic  word_ready,
    output logic  overrun
);

    logic    tick;
    byte_t   rx_byte;
    logic    byte_valid;
    byte_t   fifo_byte;
    logic    fifo_valid;
    credit_t credit_return;

    baud_tick_gen #(
        .tick_divisor (tick_divisor)
    ) baud_tick_gen_i (
        .clock (clock),
        .reset (reset),
        .tick  (tick)
    );

    uart_rx uart_rx_i (
        .clock      (clock),
        .reset      (reset),
        .tick       (tick),
        .rxd        (rxd),
        .rx_byte    (rx_byte),
        .byte_valid (byte_valid)
    );

    rx_fifo #(
        .fifo_depth (fifo_depth),
        .credits    (credits)
    ) rx_fifo_i (
        .clock         (clock),
        .reset         (reset),
        .rx_byte       (rx_byte),
        .byte_valid    (byte_valid),
        .fifo_byte     (fifo_byte),
        .fifo_valid    (fifo_valid),
        .credit_return (credit_return),
        .overrun       (overrun)
    );

    word_assembler word_assembler_i (
        .clock         (clock),
        .reset         (reset),
        .fifo_byte     (fifo_byte),
        .fifo_valid    (fifo_valid),
        .credit_return (credit_return),
        .word          (word),
        .word_valid    (word_valid),
        .word_ready    (word_ready)
    );

endmodule

// ==== sim/serial_rx_assert.sv ====
`timescale 1ns/100ps

module serial_rx_assert
    import stream_pkg::*;
(
    input logic  clock,
    input logic  reset,
    input word_t word,
    input logic  word_valid,
    input logic  word_ready,
    input logic  byte_valid,
    input logic  fifo_valid,
    input logic  overrun
);

    int failures = 0;

    // a stalled word keeps its value and stays offered
    word_held: assert property (@(posedge clock) disable iff (reset)
        word_valid && !word_ready |=> word_valid && $stable(word))
    else begin
        failures++;
        $error("word changed or was withdrawn while word_ready was low");
    end

    strobes_known: assert property (@(posedge clock) disable iff (reset)
        !$isunknown({byte_valid, fifo_valid}))
    else begin
        failures++;
        $error("byte_valid or fifo_valid is unknown");
    end

    // sticky until reset
    overrun_sticky: assert property (@(posedge clock)
        overrun && !reset |=> overrun)
    else begin
        failures++;
        $error("overrun fell without reset");
    end

endmodule

bind serial_rx_top serial_rx_assert serial_rx_assert_i (
    .clock      (clock),
    .reset      (reset),
    .word       (word),
    .word_valid (word_valid),
    .word_ready (word_ready),
    .byte_valid (byte_valid),
    .fifo_valid (fifo_valid),
    .overrun    (overrun)
);

// ==== sim/serial_rx_tb.sv ====
`timescale 1ns/100ps

module serial_rx_tb
    import uart_pkg::*;
    import stream_pkg::*;
();

    localparam int tick_divisor = 4;
    localparam int fifo_depth   = 8;
    localparam int bit_clocks   = oversample * tick_divisor;   // 64 clocks per bit
    localparam int frame_clocks = (data_bits + 2) * bit_clocks;
    localparam int word_timeout = 3 * frame_clocks;

    logic  clock;
    logic  reset;
    logic  rxd;
    logic  word_ready;
    word_t word;
    logic  word_valid;
    logic  overrun;

    int          error_count;
    int          check_count;
    logic [31:0] lcg_state = 32'he58d;

    serial_rx_top #(
        .tick_divisor (tick_divisor),
        .fifo_depth   (fifo_depth),
        .credits      (2)
    ) serial_rx_top_i (
        .clock      (clock),
        .reset      (reset),
        .rxd        (rxd),
        .word       (word),
        .word_valid (word_valid),
        .word_ready (word_ready),
        .overrun    (overrun)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    function automatic byte_t random_byte();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[23:16];   // upper bits, low ones cycle fast
    endfunction

    task automatic apply_reset();
        reset = 1'b1;
        rxd   = 1'b1;
        repeat (2) @(negedge clock);
        reset = 1'b0;
    endtask

    task automatic idle_line(input int bits);
        rxd = 1'b1;
        repeat (bits * bit_clocks) @(negedge clock);
    endtask

    task automatic send_byte(input byte_t value);
        rxd = 1'b0;   // start bit
        repeat (bit_clocks) @(negedge clock);
        for (int i = 0; i < data_bits; i++) begin
            rxd = value[i];
            repeat (bit_clocks) @(negedge clock);
        end
        rxd = 1'b1;   // stop bit
        repeat (bit_clocks) @(negedge clock);
    endtask

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Error %s: expected overrun %b, actual %b", name, expected, actual);
        end
    endtask

    task automatic expect_word(input string name, input word_t expected);
        int waited;
        waited = 0;
        while (word_valid !== 1'b1 && waited < word_timeout) begin
            @(negedge clock);
            waited++;
        end
        if (word_valid !== 1'b1) begin
            error_count++;
            $display("%s: timed out after %0d clocks waiting for word_valid", name, waited);
        end else begin
            check_word(name, expected, word);
            word_ready = 1'b1;
            @(negedge clock);
            word_ready = 1'b0;
        end
    endtask

    task automatic expect_no_word(input string name, input int cycles);
        logic seen;
        seen = 1'b0;
        for (int i = 0; i < cycles && !seen; i++) begin
            @(negedge clock);
            if (word_valid === 1'b1) begin
                seen = 1'b1;
            end
        end
        check_count++;
        if (seen) begin
            error_count++;
            $display("%s: a word appeared where none was expected", name);
        end
    endtask

    task automatic single_pair();
        byte_t first;
        byte_t second;
        first  = 8'h3c;
        second = 8'ha5;
        send_byte(first);
        send_byte(second);
        expect_word("single_pair", {second, first});
        check_flag("single_pair", 1'b0, overrun);
    endtask

    task automatic random_stream();
        byte_t stream [20];
        for (int i = 0; i < 20; i++) begin
            stream[i] = random_byte();
        end
        fork
            begin
                for (int i = 0; i < 20; i++) begin
                    send_byte(stream[i]);
                end
            end
            begin
                for (int k = 0; k < 10; k++) begin
                    expect_word("random_stream", {stream[2*k+1], stream[2*k]});
                end
            end
        join
    endtask

    task automatic backpressure_overrun();
        byte_t stream [14];
        word_ready = 1'b0;
        for (int i = 0; i < 14; i++) begin
            stream[i] = random_byte();
        end
        for (int i = 0; i < 14; i++) begin
            send_byte(stream[i]);
        end
        idle_line(2);
        check_flag("backpressure_overrun", 1'b1, overrun);
        // 2 bytes in the assembler, fifo_depth in the FIFO, the rest dropped
        for (int k = 0; k < (2 + fifo_depth) / 2; k++) begin
            expect_word("backpressure_overrun", {stream[2*k+1], stream[2*k]});
        end
        expect_no_word("backpressure_overrun", 2 * frame_clocks);
    endtask

    task automatic glitch_reject();
        rxd = 1'b0;
        repeat (tick_divisor) @(negedge clock);   // one tick wide
        idle_line(2);
        send_byte(8'h81);
        send_byte(8'h7e);
        expect_word("glitch_reject", 16'h7e81);
        expect_no_word("glitch_reject", frame_clocks);
    endtask

    task automatic reset_recovery();
        byte_t partial;
        partial = 8'h5a;
        send_byte(8'hc3);   // leaves half a word in the assembler
        rxd = 1'b0;
        repeat (bit_clocks) @(negedge clock);
        for (int i = 0; i < 3; i++) begin
            rxd = partial[i];
            repeat (bit_clocks) @(negedge clock);
        end
        apply_reset();
        check_flag("reset_recovery", 1'b0, overrun);
        idle_line(2);
        send_byte(8'h12);
        send_byte(8'h34);
        expect_word("reset_recovery", 16'h3412);
        expect_no_word("reset_recovery", frame_clocks);
    endtask

    initial begin
        int total;
        error_count = 0;
        check_count = 0;
        reset       = 1'b1;
        rxd         = 1'b1;
        word_ready  = 1'b0;
        apply_reset();
        idle_line(2);

        single_pair();
        random_stream();
        backpressure_overrun();
        glitch_reject();
        reset_recovery();

        total = error_count + serial_rx_top_i.serial_rx_assert_i.failures;
        $display("checks %0d, errors %0d, assertion failures %0d",
                 check_count, error_count, serial_rx_top_i.serial_rx_assert_i.failures);
        if (total == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== serial_rx.f ====
logic/uart_pkg.sv
logic/stream_pkg.sv
logic/baud_tick_gen.sv
logic/uart_rx.sv
logic/rx_fifo.sv
logic/word_assembler.sv
logic/serial_rx_top.sv
sim/serial_rx_assert.sv
sim/serial_rx_tb.sv

// ==== Bender.yml ====
package:
  name: serial_rx

sources:
  # packages first, the RTL modules import them
  - files:
      - logic/uart_pkg.sv
      - logic/stream_pkg.sv
      - logic/baud_tick_gen.sv
      - logic/uart_rx.sv
      - logic/rx_fifo.sv
      - logic/word_assembler.sv
      - logic/serial_rx_top.sv

  - target: simulation
    files:
      - sim/serial_rx_assert.sv
      - sim/serial_rx_tb.sv
